//--- logic/link_timing_pkg.sv
package link_timing_pkg;

    // ==================================================
    // Bit timing and frame layout
    // ==================================================
    localparam int clk_per_bit     = 16;
    localparam int half_bit        = clk_per_bit / 2;  // Receiver checks the start bit here
    localparam int frame_data_bits = 8;
    localparam int bit_ctr_w       = $clog2(clk_per_bit + 1);

    typedef logic [bit_ctr_w-1:0] bit_ctr_t;
    typedef logic [$clog2(frame_data_bits)-1:0] bit_idx_t;

    // ==================================================
    // State machines
    // ==================================================
    typedef enum logic [1:0] {
        tx_idle, tx_start_bit, tx_data_bits, tx_stop_bit
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle, rx_start_bit, rx_data_bits, rx_stop_bit
    } rx_state_t;

endpackage

//--- logic/word_pkg.sv
package word_pkg;

    // A word goes out as one frame per byte, byte 0 first
    localparam int bytes_per_word = 8;
    localparam int byte_w         = 8;
    localparam int word_w         = bytes_per_word * byte_w;

    typedef logic [word_w-1:0] word_t;
    typedef logic [byte_w-1:0] byte_t;
    typedef logic [$clog2(bytes_per_word)-1:0] byte_idx_t;

endpackage

//--- logic/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
    parameter int depth = 4  // Power of two, at least 2
) (
    input  logic            clk,
    input  logic            rst,
    input  word_pkg::word_t in_data,
    input  logic            in_valid,
    output logic            in_ready,
    output word_pkg::word_t out_data,
    output logic            out_valid,
    input  logic            out_ready
);
    import word_pkg::*;

    localparam int ptr_w = $clog2(depth);

    word_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != (ptr_w + 1)'(depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps on its own since depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Push and pop together leave the count alone
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

//--- logic/word_serializer.sv
`timescale 1ns/1ps

module word_serializer (
    input  logic            clk,
    input  logic            rst,
    input  word_pkg::word_t data,
    input  logic            valid,
    output logic            ready,
    input  logic            hold,
    output logic            tx,
    output logic            busy
);
    import link_timing_pkg::*;
    import word_pkg::*;

    tx_state_t state;
    bit_ctr_t  ctr;
    bit_idx_t  bit_idx;
    byte_idx_t byte_idx;
    word_t     shreg;
    logic      last_byte;
    logic      bit_done;

    assign ready     = (state == tx_idle) && !hold;
    assign last_byte = (byte_idx == byte_idx_t'(bytes_per_word - 1));

    // The last stop bit is one clock short, the idle cycle after it fills the gap
    // so that a queued word starts right on time
    assign bit_done = (state == tx_stop_bit && last_byte) ?
                      (ctr == bit_ctr_t'(clk_per_bit - 2)) :
                      (ctr == bit_ctr_t'(clk_per_bit - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= tx_idle;
            tx       <= 1'b1;
            busy     <= 1'b0;
            ctr      <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
        end else begin
            ctr <= ctr + 1'b1;
            case (state)
                tx_idle: begin
                    ctr      <= '0;
                    bit_idx  <= '0;
                    byte_idx <= '0;
                    busy     <= hold;
                    if (valid && ready) begin
                        state <= tx_start_bit;
                        tx    <= 1'b0;
                        busy  <= 1'b1;
                    end
                end
                tx_start_bit: if (bit_done) begin
                    ctr   <= '0;
                    state <= tx_data_bits;
                    tx    <= shreg[0];
                end
                tx_data_bits: if (bit_done) begin
                    ctr     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == bit_idx_t'(frame_data_bits - 1)) begin
                        state <= tx_stop_bit;
                        tx    <= 1'b1;
                    end else begin
                        tx <= shreg[1];  // Next bit, shreg shifts on this same edge
                    end
                end
                tx_stop_bit: if (bit_done) begin
                    ctr <= '0;
                    if (last_byte) begin
                        state <= tx_idle;
                        busy  <= hold;
                    end else begin
                        state    <= tx_start_bit;
                        tx       <= 1'b0;
                        byte_idx <= byte_idx + 1'b1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (valid && ready) begin
            shreg <= data;
        end else if (state == tx_data_bits && bit_done) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

//--- logic/byte_receiver.sv
`timescale 1ns/1ps

module byte_receiver (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx,
    output word_pkg::byte_t byte_data,
    output logic            byte_valid,
    output logic            frame_error
);
    import link_timing_pkg::*;
    import word_pkg::*;

    rx_state_t state;
    bit_ctr_t  ctr;
    bit_idx_t  bit_idx;
    byte_t     shreg;
    logic      rx_meta;
    logic      rx_sync;
    logic      rx_prev;

    assign byte_data = shreg;

    // ==================================================
    // Input synchronizer and start edge
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // ==================================================
    // Frame FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= rx_idle;
            ctr         <= '0;
            bit_idx     <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
            ctr         <= ctr + 1'b1;
            case (state)
                rx_idle: begin
                    ctr     <= '0;
                    bit_idx <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= rx_start_bit;
                    end
                end
                rx_start_bit: if (ctr == bit_ctr_t'(half_bit - 1)) begin
                    ctr   <= '0;
                    state <= rx_sync ? rx_idle : rx_data_bits;  // High again means a glitch
                end
                rx_data_bits: if (ctr == bit_ctr_t'(clk_per_bit - 1)) begin
                    ctr     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == bit_idx_t'(frame_data_bits - 1)) begin
                        state <= rx_stop_bit;
                    end
                end
                rx_stop_bit: if (ctr == bit_ctr_t'(clk_per_bit - 1)) begin
                    state       <= rx_idle;
                    byte_valid  <= rx_sync;
                    frame_error <= !rx_sync;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // LSB arrives first, so bits enter at the top and move down
    always_ff @(posedge clk) begin
        if (state == rx_data_bits && ctr == bit_ctr_t'(clk_per_bit - 1)) begin
            shreg <= {rx_sync, shreg[$bits(byte_t)-1:1]};
        end
    end

endmodule

//--- logic/word_assembler.sv
`timescale 1ns/1ps

module word_assembler (
    input  logic            clk,
    input  logic            rst,
    input  word_pkg::byte_t byte_data,
    input  logic            byte_valid,
    input  logic            frame_error,
    output word_pkg::word_t data,
    output logic            valid,
    input  logic            ready,
    output logic            overrun
);
    import word_pkg::*;

    byte_idx_t idx;
    word_t     asm_word;
    logic      word_done;
    logic      slot_free;

    assign word_done = byte_valid && (idx == byte_idx_t'(bytes_per_word - 1));
    assign slot_free = !valid || ready;  // Held word leaves on this edge or there is none

    always_ff @(posedge clk) begin
        if (rst) begin
            idx     <= '0;
            valid   <= 1'b0;
            overrun <= 1'b0;
        end else begin
            overrun <= 1'b0;
            if (frame_error) begin
                idx <= '0;  // Partial word is thrown away
            end else if (byte_valid) begin
                idx <= idx + 1'b1;
            end
            if (word_done && slot_free) begin
                valid <= 1'b1;
            end else if (word_done) begin
                overrun <= 1'b1;
            end else if (ready) begin
                valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            asm_word[idx*$bits(byte_t) +: $bits(byte_t)] <= byte_data;
        end
        if (word_done && slot_free) begin
            data <= {byte_data, asm_word[$bits(word_t)-$bits(byte_t)-1:0]};
        end
    end

endmodule

//--- logic/word_link.sv
`timescale 1ns/1ps

module word_link (
    input  logic            clk,
    input  logic            rst,
    input  word_pkg::word_t tx_data,
    input  logic            tx_valid,
    output logic            tx_ready,
    input  logic            hold,
    output logic            tx,
    input  logic            rx,
    output word_pkg::word_t rx_data,
    output logic            rx_valid,
    input  logic            rx_ready,
    output logic            tx_busy,
    output logic            frame_error,
    output logic            overrun
);
    import word_pkg::*;

    word_t q_data;
    logic  q_valid;
    logic  q_ready;
    byte_t rx_byte;
    logic  byte_valid;

    // ==================================================
    // Transmit path
    // ==================================================
    word_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (tx_data),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_data  (q_data),
        .out_valid (q_valid),
        .out_ready (q_ready)
    );

    word_serializer u_serializer (
        .clk   (clk),
        .rst   (rst),
        .data  (q_data),
        .valid (q_valid),
        .ready (q_ready),
        .hold  (hold),
        .tx    (tx),
        .busy  (tx_busy)
    );

    // ==================================================
    // Receive path
    // ==================================================
    byte_receiver u_receiver (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .byte_data   (rx_byte),
        .byte_valid  (byte_valid),
        .frame_error (frame_error)
    );

    word_assembler u_assembler (
        .clk         (clk),
        .rst         (rst),
        .byte_data   (rx_byte),
        .byte_valid  (byte_valid),
        .frame_error (frame_error),  // Also goes out on the top port
        .data        (rx_data),
        .valid       (rx_valid),
        .ready       (rx_ready),
        .overrun     (overrun)
    );

endmodule

//--- bench/word_link_sva.sv
`timescale 1ns/1ps

module word_link_sva (
    input logic            clk,
    input logic            rst,
    input logic            tx,
    input logic            tx_busy,
    input word_pkg::word_t tx_data,
    input logic            tx_valid,
    input logic            tx_ready,
    input word_pkg::word_t rx_data,
    input logic            rx_valid,
    input logic            rx_ready
);
    int fails = 0;  // Read by the testbench at the end of the run

    tx_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
        else begin
            $error("tx is low while tx_busy is low");
            fails++;
        end

    // Both handshakes hold valid and data until the transfer
    rx_hold: assert property (@(posedge clk) disable iff (rst)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_data))
        else begin
            $error("rx_valid or rx_data changed before rx_ready");
            fails++;
        end

    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else begin
            $error("tx_valid or tx_data changed while tx_ready was low");
            fails++;
        end

endmodule

bind word_link word_link_sva u_sva (.*);

//--- bench/word_link_tb.sv
`timescale 1ns/1ps

module word_link_tb;
    import link_timing_pkg::*;
    import word_pkg::*;

    localparam int word_cycles = bytes_per_word * 10 * clk_per_bit;
    localparam int timeout     = 10 * word_cycles;

    logic        clk = 1'b0;
    logic        rst;
    logic        tx_valid, tx_ready, hold, tx, line, kill, saw_full;
    logic        rx_valid, rx_ready, tx_busy, frame_error, overrun;
    word_t       tx_data, rx_data;
    logic [31:0] seed = 32'hf3b34d28;
    word_t       exp_q[$];
    int          rx_cycles[$];
    int          seen[3];  // Handshakes, frame errors, overruns
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          err_mark, rx_base, ev_base, latency;

    always #50 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;
    always @(posedge clk) line <= kill ? 1'b0 : tx;  // Loopback that kill can pull low

    word_link u_word_link (.*, .rx(line));

    function automatic logic [31:0] lcg_step();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t random_word();
        return {lcg_step(), lcg_step()};
    endfunction

    // Words come back in the order the FIFO accepted them
    function automatic word_t expected_word();
        return exp_q.pop_front();
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout waiting for %s", what);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic wait_seen(input int kind, input int target, input string what);
        int n;
        n = 0;
        while (seen[kind] < target) begin
            @(posedge clk);
            n++;
            if (n > timeout) give_up(what);
        end
    endtask

    task automatic wait_start_bit();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > timeout) give_up("a start bit on tx");
        end while (tx !== 1'b0);
    endtask

    task automatic send_word(input word_t word);
        int n;
        n = 0;
        @(posedge clk);
        tx_data  <= word;
        tx_valid <= 1'b1;
        do begin
            @(posedge clk);
            n++;
            if (!tx_ready) saw_full = 1'b1;
            if (n > timeout) give_up("tx_ready");
        end while (!tx_ready);
        tx_valid <= 1'b0;
        exp_q.push_back(word);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "errors");
        err_mark = errors;
    endtask

    // ==================================================
    // Comparison and event counting
    // ==================================================
    always @(posedge clk) begin
        if (!rst) begin
            if (frame_error) seen[1]++;
            if (overrun) seen[2]++;
            if (rx_valid && rx_ready) begin
                expect_true(exp_q.size() > 0, "a word arrived on rx_data that was never sent");
                if (exp_q.size() > 0) check("rx_data", rx_data, expected_word());
                rx_cycles.push_back(cycle);
                seen[0]++;
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        rst      = 1'b1;
        tx_data  = '0;
        tx_valid = 1'b0;
        hold     = 1'b0;
        rx_ready = 1'b1;
        kill     = 1'b0;
        line     = 1'b1;
        saw_full = 1'b0;
        err_mark = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("tx", tx, 1'b1);
        check("tx_busy", tx_busy, 1'b0);
        check("rx_valid", rx_valid, 1'b0);
        check("frame_error", frame_error, 1'b0);
        check("overrun", overrun, 1'b0);
        finish_test("reset values");

        rx_base = seen[0];
        send_word(random_word());
        wait_start_bit();
        latency = cycle;
        wait_seen(0, rx_base + 1, "the looped-back word");
        latency = rx_cycles[rx_base] - latency - word_cycles;
        expect_true(latency >= -clk_per_bit / 2 && latency <= clk_per_bit / 2,
                    "word did not arrive 80 bit times after its start bit");
        finish_test("single word");

        rx_base  = seen[0];
        saw_full = 1'b0;
        repeat (6) send_word(random_word());
        wait_seen(0, rx_base + 6, "six burst words");
        expect_true(saw_full, "tx_ready never dropped during the burst");
        for (int i = rx_base + 1; i < rx_base + 6; i++) begin
            expect_true(rx_cycles[i] - rx_cycles[i-1] == word_cycles,
                        "gap on the line between burst words");
        end
        finish_test("burst");

        rx_base = seen[0];
        hold <= 1'b1;
        send_word(random_word());
        repeat (3 * clk_per_bit) begin
            @(posedge clk);
            check("tx", tx, 1'b1);
            check("tx_busy", tx_busy, 1'b1);
        end
        hold <= 1'b0;
        wait_seen(0, rx_base + 1, "the word sent after hold");
        finish_test("hold");

        ev_base = seen[2];
        rx_ready <= 1'b0;
        send_word(random_word());
        send_word(random_word());
        wait_seen(2, ev_base + 1, "overrun");
        check("rx_valid", rx_valid, 1'b1);
        check("rx_data", rx_data, exp_q[0]);
        void'(exp_q.pop_back());  // Second word is lost in the DUT
        rx_base = seen[0];
        rx_ready <= 1'b1;
        wait_seen(0, rx_base + 1, "the held word on rx_data");
        expect_true(seen[2] == ev_base + 1, "overrun did not pulse exactly once");
        finish_test("overrun");

        // Pull the line low inside the stop bit of the last frame
        rx_base = seen[0];
        ev_base = seen[1];
        send_word(random_word());
        wait_start_bit();
        repeat (7 * 10 * clk_per_bit + 9 * clk_per_bit + 1) @(posedge clk);
        kill <= 1'b1;
        repeat (clk_per_bit - 4) @(posedge clk);
        kill <= 1'b0;
        wait_seen(1, ev_base + 1, "frame_error");
        expect_true(seen[0] == rx_base, "the corrupted word was delivered");
        void'(exp_q.pop_back());
        send_word(random_word());
        wait_seen(0, rx_base + 1, "the word after the framing error");
        finish_test("framing error");

        errors += u_word_link.u_sva.fails;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sources.f
logic/link_timing_pkg.sv
logic/word_pkg.sv
logic/word_fifo.sv
logic/word_serializer.sv
logic/byte_receiver.sv
logic/word_assembler.sv
logic/word_link.sv
bench/word_link_sva.sv
bench/word_link_tb.sv

//--- Bender.yml
package:
  name: word_link

sources:
  - files:
      - logic/link_timing_pkg.sv
      - logic/word_pkg.sv
      - logic/word_fifo.sv
      - logic/word_serializer.sv
      - logic/byte_receiver.sv
      - logic/word_assembler.sv
      - logic/word_link.sv
  - target: simulation
    files:
      - bench/word_link_sva.sv
      - bench/word_link_tb.sv
